// File: Bender.yml
package:
  name: rv_core

sources:
  - rv_core_pkg.sv
  - rv_dec_if.sv
  - rv_fetch.sv
  - rv_regfile.sv
  - rv_decode.sv
  - rv_execute.sv
  - rv_lsu.sv
  - rv_control.sv
  - rv_core.sv
  - target: test
    files:
      - rv_core_chk.sv
      - rv_core_scoreboard.sv
      - tb_rv_core.sv

// File: rv_control.sv
`timescale 1ns/1ns

module rv_control import rv_core_pkg::*; (
    input  logic  clk,
    input  logic  rst_i,
    rv_dec_if.dst dec,
    input  logic  mem_done_i,
    output logic  fetch_en_o,
    output logic  decode_en_o,
    output logic  exec_en_o,
    output logic  mem_start_o,
    output logic  wb_en_o,
    output logic  retire_valid_o
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        is_mem;

    assign is_mem = dec.dec.is_load || dec.dec.is_store;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= FETCH;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            FETCH:     state_d = DECODE;
            DECODE:    state_d = EXECUTE;
            // Non-memory instructions skip MEMORY
            EXECUTE:   state_d = is_mem ? MEMORY : WRITEBACK;
            MEMORY: begin
                if (mem_done_i) begin
                    state_d = WRITEBACK;
                end
            end
            WRITEBACK: state_d = FETCH;
            default:   state_d = FETCH;
        endcase
    end

    // One enable per state
    assign fetch_en_o  = (state_q == FETCH);
    assign decode_en_o = (state_q == DECODE);
    assign exec_en_o   = (state_q == EXECUTE);
    assign wb_en_o     = (state_q == WRITEBACK);

    // Issued in EXECUTE so the request is up in the first MEMORY cycle
    assign mem_start_o = (state_q == EXECUTE) && is_mem;

    assign retire_valid_o = (state_q == WRITEBACK);

endmodule

// File: rv_core.f
rv_core_pkg.sv
rv_dec_if.sv
rv_fetch.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_lsu.sv
rv_control.sv
rv_core.sv
rv_core_chk.sv
rv_core_scoreboard.sv
tb_rv_core.sv

// File: rv_core.sv
`timescale 1ns/1ns

module rv_core import rv_core_pkg::*; (
    input  logic              clk,
    input  logic              rst_i,
    output logic [XLEN-1:0]   imem_addr_o,
    input  logic [XLEN-1:0]   imem_data_i,
    output logic              dmem_req_o,
    output logic [XLEN-1:0]   dmem_addr_o,
    output logic              dmem_we_o,
    output logic [XLEN-1:0]   dmem_wdata_o,
    input  logic              dmem_ready_i,
    input  logic [XLEN-1:0]   dmem_rdata_i,
    output logic              retire_valid_o,
    output logic [XLEN-1:0]   retire_pc_o,
    output logic [REG_AW-1:0] retire_rd_o,
    output logic [XLEN-1:0]   retire_wdata_o
);

    logic              fetch_en;
    logic              decode_en;
    logic              exec_en;
    logic              mem_start;
    logic              wb_en;
    logic              mem_done;
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   inst;
    logic [REG_AW-1:0] rs1_addr;
    logic [REG_AW-1:0] rs2_addr;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic [XLEN-1:0]   exe_result;
    logic [XLEN-1:0]   next_pc;
    logic [XLEN-1:0]   mem_addr;
    logic [XLEN-1:0]   store_data;
    logic [XLEN-1:0]   load_data;
    logic [XLEN-1:0]   wb_data;
    logic              rf_we;

    rv_dec_if dec_bus ();

    rv_control u_control (
        .clk            (clk),
        .rst_i          (rst_i),
        .dec            (dec_bus.dst),
        .mem_done_i     (mem_done),
        .fetch_en_o     (fetch_en),
        .decode_en_o    (decode_en),
        .exec_en_o      (exec_en),
        .mem_start_o    (mem_start),
        .wb_en_o        (wb_en),
        .retire_valid_o (retire_valid_o)
    );

    rv_fetch u_fetch (
        .clk         (clk),
        .rst_i       (rst_i),
        .fetch_en_i  (fetch_en),
        .pc_load_i   (wb_en),
        .next_pc_i   (next_pc),
        .imem_data_i (imem_data_i),
        .pc_o        (pc),
        .inst_o      (inst)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .we_i     (rf_we),
        .waddr_i  (dec_bus.dec.rd),
        .wdata_i  (wb_data),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    rv_decode u_decode (
        .clk         (clk),
        .rst_i       (rst_i),
        .decode_en_i (decode_en),
        .inst_i      (inst),
        .pc_i        (pc),
        .rs1_addr_o  (rs1_addr),
        .rs2_addr_o  (rs2_addr),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .dec         (dec_bus.src)
    );

    rv_execute u_execute (
        .clk          (clk),
        .rst_i        (rst_i),
        .exec_en_i    (exec_en),
        .dec          (dec_bus.dst),
        .result_o     (exe_result),
        .next_pc_o    (next_pc),
        .mem_addr_o   (mem_addr),
        .store_data_o (store_data)
    );

    rv_lsu u_lsu (
        .clk          (clk),
        .rst_i        (rst_i),
        .mem_start_i  (mem_start),
        .addr_i       (mem_addr),
        .wdata_i      (store_data),
        .is_store_i   (dec_bus.dec.is_store),
        .dmem_req_o   (dmem_req_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_ready_i (dmem_ready_i),
        .dmem_rdata_i (dmem_rdata_i),
        .mem_done_o   (mem_done),
        .load_data_o  (load_data)
    );

    // Write-back select
    assign wb_data = dec_bus.dec.is_load ? load_data : exe_result;
    assign rf_we   = wb_en && dec_bus.dec.writes_rd;

    assign imem_addr_o = pc;

    // Retire reports rd as zero when nothing is written
    assign retire_pc_o    = dec_bus.pc;
    assign retire_rd_o    = dec_bus.dec.writes_rd ? dec_bus.dec.rd : '0;
    assign retire_wdata_o = wb_data;

endmodule

// File: rv_core_chk.sv
`timescale 1ns/1ns

module rv_core_chk import rv_core_pkg::*; (
    input logic            clk,
    input logic            rst_i,
    input logic [XLEN-1:0] imem_addr_o,
    input logic            dmem_req_o,
    input logic [XLEN-1:0] dmem_addr_o,
    input logic            dmem_we_o,
    input logic [XLEN-1:0] dmem_wdata_o,
    input logic            dmem_ready_i,
    input logic            retire_valid_o
);

    int unsigned fail_cnt = 0;

    // Request and its fields hold until ready
    a_req_stable: assert property (@(posedge clk) disable iff (rst_i)
        dmem_req_o && !dmem_ready_i |=> dmem_req_o && $stable(dmem_addr_o) &&
                                        $stable(dmem_we_o) && $stable(dmem_wdata_o))
    else begin
        $error("data memory request changed before ready");
        fail_cnt++;
    end

    a_retire_pulse: assert property (@(posedge clk) disable iff (rst_i)
        retire_valid_o |=> !retire_valid_o)
    else begin
        $error("retire valid lasted more than one cycle");
        fail_cnt++;
    end

    a_no_retire_in_mem: assert property (@(posedge clk) disable iff (rst_i)
        !(retire_valid_o && dmem_req_o))
    else begin
        $error("retire while a data memory request is pending");
        fail_cnt++;
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (rst_i)
        imem_addr_o[1:0] == 2'b00)
    else begin
        $error("instruction address not word aligned");
        fail_cnt++;
    end

endmodule

// File: rv_core_pkg.sv
package rv_core_pkg;

    // Datapath widths
    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    // RV32I major opcodes used by this core
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    // PASS_B forwards operand b, which LUI uses for its immediate
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    // Decoded instruction as handed from decode to execute
    typedef struct packed {
        alu_op_e             alu_op;
        logic [REG_AW-1:0]   rd;
        logic                use_imm;
        logic [XLEN-1:0]     imm;
        logic                is_load;
        logic                is_store;
        logic                is_branch;
        logic                is_jal;
        logic                branch_ne;
        logic                writes_rd;
    } decoded_t;

    // Sequencing states, one instruction at a time
    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK
    } ctrl_state_e;

endpackage

// File: rv_core_scoreboard.sv
`timescale 1ns/1ns

module rv_core_scoreboard import rv_core_pkg::*; (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              retire_valid_i,
    input  logic [XLEN-1:0]   retire_pc_i,
    input  logic [REG_AW-1:0] retire_rd_i,
    input  logic [XLEN-1:0]   retire_wdata_i,
    input  logic              dmem_req_i,
    input  logic              dmem_ready_i,
    input  logic              dmem_we_i,
    input  logic [XLEN-1:0]   dmem_addr_i,
    input  logic [XLEN-1:0]   dmem_wdata_i,
    input  logic [XLEN-1:0]   model_inst_i,
    output logic [XLEN-1:0]   model_pc_o,
    output int                mismatch_cnt_o,
    output int                other_cnt_o
);

    logic [XLEN-1:0] regs [0:31];
    logic [XLEN-1:0] mem [0:63];
    logic            store_seen;
    int              cycle;
    int              last_retire;

    // Arithmetic as the ISA defines it
    function automatic logic [XLEN-1:0] alu_model(input logic [2:0] f3, input logic sub,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        case (f3)
            3'b000:  alu_model = sub ? a - b : a + b;
            3'b010:  alu_model = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  alu_model = a ^ b;
            3'b110:  alu_model = a | b;
            3'b111:  alu_model = a & b;
            default: alu_model = a + b;
        endcase
    endfunction

    initial begin
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'hd00d_0000 | (i << 2);
        end
        model_pc_o     = RESET_PC;
        mismatch_cnt_o = 0;
        other_cnt_o    = 0;
        store_seen     = 1'b0;
        cycle          = 0;
        last_retire    = -1;
    end

    // Store is checked before its retire, against the state the model holds then
    task automatic check_store();
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] exp_addr;
        inst     = model_inst_i;
        exp_addr = regs[inst[19:15]] + {{20{inst[31]}}, inst[31:25], inst[11:7]};
        if (inst[6:0] != OP_STORE) begin
            other_cnt_o++;
            $display("error at %0t ns: data memory write from a non-store instruction", $time);
        end else if (dmem_addr_i != exp_addr || dmem_wdata_i != regs[inst[24:20]]) begin
            mismatch_cnt_o++;
            $display("mismatch at %0t ns: store %h <= %h, expected %h <= %h", $time,
                     dmem_addr_i, dmem_wdata_i, exp_addr, regs[inst[24:20]]);
        end
        store_seen = 1'b1;
    endtask

    task automatic check_retire();
        logic [XLEN-1:0]   inst;
        logic [XLEN-1:0]   a;
        logic [XLEN-1:0]   b;
        logic [XLEN-1:0]   imm_i;
        logic [XLEN-1:0]   exp_wd;
        logic [XLEN-1:0]   npc;
        logic [REG_AW-1:0] exp_rd;
        logic              mem_op;
        inst   = model_inst_i;
        a      = regs[inst[19:15]];
        b      = regs[inst[24:20]];
        imm_i  = {{20{inst[31]}}, inst[31:20]};
        exp_wd = '0;
        exp_rd = '0;
        mem_op = 1'b0;
        npc    = model_pc_o + 4;
        case (inst[6:0])
            OP_R: begin
                exp_wd = alu_model(inst[14:12], inst[30], a, b);
                exp_rd = inst[11:7];
            end
            OP_I: begin
                exp_wd = alu_model(inst[14:12], 1'b0, a, imm_i);
                exp_rd = inst[11:7];
            end
            OP_LUI: begin
                exp_wd = {inst[31:12], 12'b0};
                exp_rd = inst[11:7];
            end
            OP_LOAD: begin
                exp_wd = mem[(a + imm_i) >> 2];
                exp_rd = inst[11:7];
                mem_op = 1'b1;
            end
            OP_STORE: begin
                mem[(a + {{20{inst[31]}}, inst[31:25], inst[11:7]}) >> 2] = b;
                mem_op = 1'b1;
                if (!store_seen) begin
                    other_cnt_o++;
                    $display("error at %0t ns: store retired without a data memory write",
                             $time);
                end
            end
            OP_BRANCH: begin
                if ((a == b) != inst[12]) begin
                    npc = model_pc_o + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                        inst[11:8], 1'b0};
                end
            end
            OP_JAL: begin
                exp_wd = model_pc_o + 4;
                exp_rd = inst[11:7];
                npc    = model_pc_o + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                       inst[30:21], 1'b0};
            end
            default: ;
        endcase
        if (retire_pc_i != model_pc_o || retire_rd_i != exp_rd ||
            (exp_rd != 0 && retire_wdata_i != exp_wd)) begin
            mismatch_cnt_o++;
            $display("mismatch at %0t ns: retire pc %h rd %0d data %h, expected pc %h rd %0d data %h",
                     $time, retire_pc_i, retire_rd_i, retire_wdata_i, model_pc_o, exp_rd, exp_wd);
        end
        // Non-memory instructions take exactly four cycles
        if (!mem_op && last_retire >= 0 && cycle - last_retire != 4) begin
            mismatch_cnt_o++;
            $display("mismatch at %0t ns: retire of pc %h came %0d cycles after the last one",
                     $time, model_pc_o, cycle - last_retire);
        end
        if (exp_rd != 0) begin
            regs[exp_rd] = exp_wd;
        end
        last_retire = cycle;
        store_seen  = 1'b0;
        model_pc_o  = npc;
    endtask

    always @(negedge clk) begin
        cycle++;
        if (rst_i) begin
            if (dmem_req_i || retire_valid_i) begin
                other_cnt_o++;
                $display("error at %0t ns: request or retire active during reset", $time);
            end
        end else begin
            if (dmem_req_i && dmem_ready_i && dmem_we_i) begin
                check_store();
            end
            if (retire_valid_i) begin
                check_retire();
            end
        end
    end

endmodule

// File: rv_dec_if.sv
`timescale 1ns/1ns

interface rv_dec_if import rv_core_pkg::*; ();

    // Decoded fields, held from the end of DECODE until the next DECODE
    decoded_t        dec;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] pc;

    // Written by decode
    modport src (
        output dec,
        output rs1_val,
        output rs2_val,
        output pc
    );

    // Read by execute and control
    modport dst (
        input dec,
        input rs1_val,
        input rs2_val,
        input pc
    );

endinterface

// File: rv_decode.sv
`timescale 1ns/1ns

module rv_decode import rv_core_pkg::*; (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              decode_en_i,
    input  logic [XLEN-1:0]   inst_i,
    input  logic [XLEN-1:0]   pc_i,
    output logic [REG_AW-1:0] rs1_addr_o,
    output logic [REG_AW-1:0] rs2_addr_o,
    input  logic [XLEN-1:0]   rs1_data_i,
    input  logic [XLEN-1:0]   rs2_data_i,
    rv_dec_if.src             dec
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            funct7_b5;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    decoded_t        dec_d;

    // Shared by register and immediate arithmetic
    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  alu_sel = sub ? ALU_SUB : ALU_ADD;
            3'b010:  alu_sel = ALU_SLT;
            3'b100:  alu_sel = ALU_XOR;
            3'b110:  alu_sel = ALU_OR;
            3'b111:  alu_sel = ALU_AND;
            default: alu_sel = ALU_ADD;
        endcase
    endfunction

    assign opcode     = inst_i[6:0];
    assign funct3     = inst_i[14:12];
    assign funct7_b5  = inst_i[30];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    // Immediate formats
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                    inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};

    always_comb begin
        dec_d        = '0;
        dec_d.alu_op = ALU_ADD;
        dec_d.rd     = inst_i[11:7];
        case (opcode)
            OP_R: begin
                dec_d.alu_op    = alu_sel(funct3, funct7_b5);
                dec_d.writes_rd = 1'b1;
            end
            OP_I: begin
                dec_d.alu_op    = alu_sel(funct3, 1'b0);
                dec_d.use_imm   = 1'b1;
                dec_d.imm       = imm_i;
                dec_d.writes_rd = 1'b1;
            end
            OP_LUI: begin
                dec_d.alu_op    = ALU_PASS_B;
                dec_d.use_imm   = 1'b1;
                dec_d.imm       = imm_u;
                dec_d.writes_rd = 1'b1;
            end
            OP_LOAD: begin
                dec_d.use_imm   = 1'b1;
                dec_d.imm       = imm_i;
                dec_d.is_load   = 1'b1;
                dec_d.writes_rd = 1'b1;
            end
            OP_STORE: begin
                dec_d.use_imm  = 1'b1;
                dec_d.imm      = imm_s;
                dec_d.is_store = 1'b1;
            end
            OP_BRANCH: begin
                dec_d.imm       = imm_b;
                dec_d.is_branch = 1'b1;
                // funct3 bit 0 separates BNE from BEQ
                dec_d.branch_ne = funct3[0];
            end
            OP_JAL: begin
                dec_d.imm       = imm_j;
                dec_d.is_jal    = 1'b1;
                dec_d.writes_rd = 1'b1;
            end
            // Unknown opcodes fall through as a no-write, PC plus four
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            dec.dec <= '0;
        end else if (decode_en_i) begin
            dec.dec <= dec_d;
        end
    end

    // Operands and PC for execute
    always_ff @(posedge clk) begin
        if (decode_en_i) begin
            dec.rs1_val <= rs1_data_i;
            dec.rs2_val <= rs2_data_i;
            dec.pc      <= pc_i;
        end
    end

endmodule

// File: rv_execute.sv
`timescale 1ns/1ns

module rv_execute import rv_core_pkg::*; (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            exec_en_i,
    rv_dec_if.dst           dec,
    output logic [XLEN-1:0] result_o,
    output logic [XLEN-1:0] next_pc_o,
    output logic [XLEN-1:0] mem_addr_o,
    output logic [XLEN-1:0] store_data_o
);

    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] target;
    logic            taken;
    logic [XLEN-1:0] result_q;
    logic [XLEN-1:0] next_pc_q;
    logic [XLEN-1:0] mem_addr_q;
    logic [XLEN-1:0] store_data_q;

    assign op_b = dec.dec.use_imm ? dec.dec.imm : dec.rs2_val;

    always_comb begin
        case (dec.dec.alu_op)
            ALU_ADD:    alu_res = dec.rs1_val + op_b;
            ALU_SUB:    alu_res = dec.rs1_val - op_b;
            ALU_AND:    alu_res = dec.rs1_val & op_b;
            ALU_OR:     alu_res = dec.rs1_val | op_b;
            ALU_XOR:    alu_res = dec.rs1_val ^ op_b;
            ALU_SLT:    alu_res = XLEN'($signed(dec.rs1_val) < $signed(op_b));
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // Branch and jump targets share one adder
    assign pc_plus4 = dec.pc + XLEN'(4);
    assign target   = dec.pc + dec.dec.imm;
    assign taken    = dec.dec.is_branch &&
                      ((dec.rs1_val == dec.rs2_val) != dec.dec.branch_ne);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            next_pc_q <= RESET_PC;
        end else if (exec_en_i) begin
            next_pc_q <= (taken || dec.dec.is_jal) ? target : pc_plus4;
        end
    end

    // Loads and stores decode as ADD with immediate, so the ALU gives the address
    always_ff @(posedge clk) begin
        if (exec_en_i) begin
            result_q     <= dec.dec.is_jal ? pc_plus4 : alu_res;
            mem_addr_q   <= alu_res;
            store_data_q <= dec.rs2_val;
        end
    end

    assign result_o     = result_q;
    assign next_pc_o    = next_pc_q;
    assign mem_addr_o   = mem_addr_q;
    assign store_data_o = store_data_q;

endmodule

// File: rv_fetch.sv
`timescale 1ns/1ns

module rv_fetch import rv_core_pkg::*; (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            fetch_en_i,
    input  logic            pc_load_i,
    input  logic [XLEN-1:0] next_pc_i,
    input  logic [XLEN-1:0] imem_data_i,
    output logic [XLEN-1:0] pc_o,
    output logic [XLEN-1:0] inst_o
);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] inst_q;

    // PC advances only at the end of write-back
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= RESET_PC;
        end else if (pc_load_i) begin
            pc_q <= next_pc_i;
        end
    end

    // Instruction memory is combinational, sample it at the end of FETCH
    always_ff @(posedge clk) begin
        if (fetch_en_i) begin
            inst_q <= imem_data_i;
        end
    end

    assign pc_o   = pc_q;
    assign inst_o = inst_q;

endmodule

// File: rv_lsu.sv
`timescale 1ns/1ns

module rv_lsu import rv_core_pkg::*; (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            mem_start_i,
    input  logic [XLEN-1:0] addr_i,
    input  logic [XLEN-1:0] wdata_i,
    input  logic            is_store_i,
    output logic            dmem_req_o,
    output logic [XLEN-1:0] dmem_addr_o,
    output logic            dmem_we_o,
    output logic [XLEN-1:0] dmem_wdata_o,
    input  logic            dmem_ready_i,
    input  logic [XLEN-1:0] dmem_rdata_i,
    output logic            mem_done_o,
    output logic [XLEN-1:0] load_data_o
);

    logic            req_q;
    logic [XLEN-1:0] load_q;

    // Request rises after mem_start and drops after the ready cycle
    always_ff @(posedge clk) begin
        if (rst_i) begin
            req_q <= 1'b0;
        end else if (mem_start_i) begin
            req_q <= 1'b1;
        end else if (dmem_ready_i) begin
            req_q <= 1'b0;
        end
    end

    assign mem_done_o = req_q && dmem_ready_i;

    // Read data is only valid in the ready cycle
    always_ff @(posedge clk) begin
        if (mem_done_o && !is_store_i) begin
            load_q <= dmem_rdata_i;
        end
    end

    // Address, data and direction come from registers held through MEMORY
    assign dmem_req_o   = req_q;
    assign dmem_addr_o  = addr_i;
    assign dmem_we_o    = is_store_i;
    assign dmem_wdata_o = wdata_i;
    assign load_data_o  = load_q;

endmodule

// File: rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile import rv_core_pkg::*; (
    input  logic              clk,
    input  logic              we_i,
    input  logic [REG_AW-1:0] waddr_i,
    input  logic [XLEN-1:0]   wdata_i,
    input  logic [REG_AW-1:0] raddr1_i,
    input  logic [REG_AW-1:0] raddr2_i,
    output logic [XLEN-1:0]   rdata1_o,
    output logic [XLEN-1:0]   rdata2_o
);

    // x1 to x31 only, x0 has no storage
    logic [XLEN-1:0] regs [1:2**REG_AW-1];

    always_ff @(posedge clk) begin
        if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Asynchronous read, x0 reads as zero
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// File: tb_rv_core.sv
`timescale 1ns/1ns

module tb_clkgen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

module tb_rv_core import rv_core_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int PROG_WORDS   = 256;
    localparam int MAX_RETIRE   = 600;
    localparam int WATCHDOG_NS  = MAX_RETIRE * 8 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;
    localparam logic [XLEN-1:0] LAST_PC = (PROG_WORDS - 1) * 4;

    logic              clk;
    logic              rst;
    logic [XLEN-1:0]   imem_addr;
    logic [XLEN-1:0]   imem_data;
    logic              dmem_req;
    logic [XLEN-1:0]   dmem_addr;
    logic              dmem_we;
    logic [XLEN-1:0]   dmem_wdata;
    logic              dmem_ready;
    logic [XLEN-1:0]   dmem_rdata;
    logic              retire_valid;
    logic [XLEN-1:0]   retire_pc;
    logic [REG_AW-1:0] retire_rd;
    logic [XLEN-1:0]   retire_wdata;
    logic [XLEN-1:0]   model_pc;
    logic [XLEN-1:0]   model_inst;
    int                mismatch_cnt;
    int                other_cnt;

    logic [XLEN-1:0] prog [0:PROG_WORDS-1];
    logic [XLEN-1:0] dmem [0:63];
    logic [15:0]     lfsr = 16'd6410;
    logic [31:0]     wait_left;
    logic            mem_busy;
    int              retire_cnt;
    logic            at_self_loop;

    tb_clkgen #(.PERIOD_NS(CLK_PERIOD)) u_clkgen (.clk_o(clk));

    rv_core UUT (
        .clk            (clk),
        .rst_i          (rst),
        .imem_addr_o    (imem_addr),
        .imem_data_i    (imem_data),
        .dmem_req_o     (dmem_req),
        .dmem_addr_o    (dmem_addr),
        .dmem_we_o      (dmem_we),
        .dmem_wdata_o   (dmem_wdata),
        .dmem_ready_i   (dmem_ready),
        .dmem_rdata_i   (dmem_rdata),
        .retire_valid_o (retire_valid),
        .retire_pc_o    (retire_pc),
        .retire_rd_o    (retire_rd),
        .retire_wdata_o (retire_wdata)
    );

    rv_core_scoreboard u_sb (
        .clk            (clk),
        .rst_i          (rst),
        .retire_valid_i (retire_valid),
        .retire_pc_i    (retire_pc),
        .retire_rd_i    (retire_rd),
        .retire_wdata_i (retire_wdata),
        .dmem_req_i     (dmem_req),
        .dmem_ready_i   (dmem_ready),
        .dmem_we_i      (dmem_we),
        .dmem_addr_i    (dmem_addr),
        .dmem_wdata_i   (dmem_wdata),
        .model_inst_i   (model_inst),
        .model_pc_o     (model_pc),
        .mismatch_cnt_o (mismatch_cnt),
        .other_cnt_o    (other_cnt)
    );

    bind rv_core rv_core_chk u_chk (
        .clk            (clk),
        .rst_i          (rst_i),
        .imem_addr_o    (imem_addr_o),
        .dmem_req_o     (dmem_req_o),
        .dmem_addr_o    (dmem_addr_o),
        .dmem_we_o      (dmem_we_o),
        .dmem_wdata_o   (dmem_wdata_o),
        .dmem_ready_i   (dmem_ready_i),
        .retire_valid_o (retire_valid_o)
    );

    // The model fetches from the same program image
    assign model_inst = prog[model_pc[9:2]];

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic build_program();
        logic [31:0] cls;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] imm;
        logic [31:0] k;
        logic [2:0]  f3;
        logic [6:0]  f7;
        int          w;
        // Registers start unknown, so the program opens by writing x1 to x7
        for (w = 0; w < 7; w++) begin
            take_bits(12, imm);
            prog[w] = {imm[11:0], 5'd0, 3'b000, 5'(w + 1), OP_I};
        end
        for (w = 7; w < PROG_WORDS - 1; w++) begin
            take_bits(4, cls);
            take_bits(3, rd);
            take_bits(3, rs1);
            take_bits(3, rs2);
            take_bits(12, imm);
            f7 = 7'b0;
            f3 = 3'b000;
            case (cls)
                1:       f7 = 7'b0100000;
                2, 7:    f3 = 3'b111;
                3, 8:    f3 = 3'b110;
                4, 9:    f3 = 3'b100;
                5:       f3 = 3'b010;
                14:      f3 = 3'b001;
                default: ;
            endcase
            if (cls <= 5) begin
                prog[w] = {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OP_R};
            end else if (cls <= 9) begin
                prog[w] = {imm[11:0], rs1[4:0], f3, rd[4:0], OP_I};
            end else if (cls == 10) begin
                take_bits(8, k);
                prog[w] = {k[7:0], imm[11:0], rd[4:0], OP_LUI};
            end else if (cls == 11) begin
                take_bits(6, k);
                prog[w] = {4'b0, k[5:0], 2'b00, 5'd0, 3'b010, rd[4:0], OP_LOAD};
            end else if (cls == 12) begin
                take_bits(6, k);
                imm = k << 2;
                prog[w] = {imm[11:5], rs2[4:0], 5'd0, 3'b010, imm[4:0], OP_STORE};
            end else begin
                // Forward 1 to 4 words, never past the final self-loop
                take_bits(2, k);
                k = k + 1;
                if (w + k > PROG_WORDS - 1) begin
                    k = PROG_WORDS - 1 - w;
                end
                imm = k << 2;
                if (cls == 15) begin
                    prog[w] = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
                end else begin
                    prog[w] = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3,
                               imm[4:1], imm[11], OP_BRANCH};
                end
            end
        end
        prog[PROG_WORDS-1] = {25'd0, OP_JAL};
    endtask

    // Memory models, driven 1 ns after the rising edge
    always @(posedge clk) begin
        #1;
        imem_data <= prog[imem_addr[9:2]];
        if (dmem_ready) begin
            dmem_ready <= 1'b0;
        end else if (dmem_req) begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                take_bits(2, wait_left);
            end
            if (wait_left == 0) begin
                mem_busy = 1'b0;
                dmem_ready <= 1'b1;
                if (dmem_we) begin
                    dmem[dmem_addr[7:2]] = dmem_wdata;
                end else begin
                    dmem_rdata <= dmem[dmem_addr[7:2]];
                end
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && retire_valid) begin
            retire_cnt++;
            if (retire_pc == LAST_PC) begin
                at_self_loop = 1'b1;
            end
        end
    end

    initial begin
        rst          = 1'b1;
        imem_data    = '0;
        dmem_ready   = 1'b0;
        dmem_rdata   = '0;
        mem_busy     = 1'b0;
        wait_left    = '0;
        retire_cnt   = 0;
        at_self_loop = 1'b0;
        for (int i = 0; i < 64; i++) begin
            dmem[i] = 32'hd00d_0000 | (i << 2);
        end
        build_program();
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
        wait (at_self_loop || retire_cnt >= MAX_RETIRE);
        @(negedge clk);
        $display("done: %0d retires, %0d mismatches, %0d other errors, %0d assertion failures",
                 retire_cnt, mismatch_cnt, other_cnt, UUT.u_chk.fail_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0 && UUT.u_chk.fail_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the core did not reach the final self-loop in %0d ns", WATCHDOG_NS);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule
